// ==== list.f ====
+incdir+.
corePkg.sv
coreRegFile.sv
coreDecode.sv
coreHazard.sv
coreExecute.sv
coreResult.sv
coreTop.sv
coreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the core testbench with Verilator, run it and look for the pass message
verilator --binary --timing -f list.f --top-module coreTb -o coreSim && \
    ./obj_dir/coreSim | tee /dev/stderr | grep -q "Done: no errors" && \
    echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== coreTb.sv ====
// ##########################################################
// Directed testbench for the RV32I core, with instruction
// and data memory models and one task per behavior
// ##########################################################
`timescale 1ns/1ps
`include "coreMacros.svh"

module coreTb;

    localparam int DONE_ADDR  = 'h1FC;
    localparam int MAX_CYCLES = 400;

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] instrF;
    logic [`XLEN-1:0] readDataM;
    logic [`XLEN-1:0] pcF;
    logic [`XLEN-1:0] dataAddrM;
    logic [`XLEN-1:0] writeDataM;
    logic             memWriteM;

    logic [31:0] instrMem [0:255];
    logic [31:0] dataMem [0:255];
    logic [31:0] storeAddrQ [$];
    logic [31:0] storeDataQ [$];
    logic        doneSeen;
    int          progLen;
    int          errors;
    int          checks;
    integer      seed;

    coreTop UUT (
        .clk(clk), .reset(reset), .instrF_i(instrF), .readDataM_i(readDataM),
        .pcF_o(pcF), .dataAddrM_o(dataAddrM), .writeDataM_o(writeDataM),
        .memWriteM_o(memWriteM)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Both memories answer in the same cycle
    assign instrF    = instrMem[pcF[9:2]];
    assign readDataM = dataMem[dataAddrM[9:2]];

    // Data memory write port and store log
    always @(posedge clk) begin
        if (memWriteM === 1'b1) begin
            dataMem[dataAddrM[9:2]] = writeDataM;
            storeAddrQ.push_back(dataAddrM);
            storeDataQ.push_back(writeDataM);
            if (dataAddrM == DONE_ADDR) begin
                doneSeen = 1'b1;
            end
        end
    end

    // RV32I instruction formats
    function automatic logic [31:0] rType(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        rType = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(input int imm, input int rs1, input int f3,
                                          input int rd, input logic [6:0] opc);
        iType = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] sType(input int imm, input int rs2, input int rs1);
        sType = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bType(input int imm, input int rs2, input int rs1,
                                          input int f3);
        bType = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                 7'b1100011};
    endfunction

    function automatic logic [31:0] jType(input int imm, input int rd);
        jType = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] uType(input int imm, input int rd);
        uType = {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] sext12(input int v);
        sext12 = {{20{v[11]}}, v[11:0]};
    endfunction

    function automatic int storeCount(input logic [31:0] addr);
        int n;
        n = 0;
        foreach (storeAddrQ[i]) begin
            if (storeAddrQ[i] == addr) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic logic [31:0] lastStore(input logic [31:0] addr);
        logic [31:0] v;
        v = 'x;
        foreach (storeAddrQ[i]) begin
            if (storeAddrQ[i] == addr) begin
                v = storeDataQ[i];
            end
        end
        return v;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkStore(input string name, input logic [31:0] addr,
                              input logic [31:0] expected);
        checks++;
        assert (storeCount(addr) == 1) else begin
            $display("%s: expected one store to address %h, saw %0d", name, addr,
                     storeCount(addr));
            errors++;
        end
        checkValue(name, expected, lastStore(addr));
    endtask

    task automatic checkNoStore(input string name, input logic [31:0] addr);
        checks++;
        assert (storeCount(addr) == 0) else begin
            $display("%s: store to address %h should have been discarded", name, addr);
            errors++;
        end
    endtask

    // Unused words hold addi x0, x0, index
    task automatic startProgram();
        for (int i = 0; i < 256; i++) begin
            instrMem[i] = iType(i, 0, 0, 0, 7'b0010011);
        end
        progLen = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        instrMem[progLen] = word;
        progLen++;
    endtask

    // Done store, then spin in place
    task automatic endProgram();
        emit(sType(DONE_ADDR, 0, 0));
        emit(jType(0, 0));
    endtask

    task automatic resetCore(input string name);
        @(posedge clk);
        reset <= 1'b1;
        repeat (15) begin
            @(posedge clk);
            @(negedge clk);
            checkValue({name, " memWrite in reset"}, 32'd0, {31'd0, memWriteM});
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkValue({name, " pc after reset"}, 32'd0, pcF);
        checkValue({name, " memWrite after reset"}, 32'd0, {31'd0, memWriteM});
        @(negedge clk);
        checkValue({name, " memWrite first cycle"}, 32'd0, {31'd0, memWriteM});
        storeAddrQ.delete();
        storeDataQ.delete();
        doneSeen = 1'b0;
    endtask

    task automatic waitDone(input string name);
        int cyc;
        cyc = 0;
        while (!doneSeen && cyc < MAX_CYCLES) begin
            @(negedge clk);
            cyc++;
        end
        checks++;
        assert (doneSeen) else begin
            $display("%s: no store to the done address within %0d cycles", name, MAX_CYCLES);
            errors++;
        end
    endtask

    task automatic testReset();
        startProgram();
        endProgram();
        resetCore("reset");
        waitDone("reset");
        checkValue("reset store count", 32'd1, storeAddrQ.size());
    endtask

    // Chain of dependent ALU ops on random operands
    task automatic testAlu(input string name);
        int          rndA;
        int          rndB;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sum;
        logic [31:0] diff;
        logic [31:0] andV;
        logic [31:0] orV;
        logic [31:0] sltV;
        logic [31:0] sltRev;
        rndA = $random(seed);
        rndB = $random(seed);
        a = sext12(rndA);
        b = sext12(rndB);
        sum    = a + b;
        diff   = sum - a;
        andV   = diff & a;
        orV    = andV | sum;
        sltV   = ($signed(orV) < $signed(diff)) ? 32'd1 : 32'd0;
        sltRev = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
        startProgram();
        emit(iType(rndA, 0, 0, 1, 7'b0010011));
        emit(iType(rndB, 0, 0, 2, 7'b0010011));
        emit(rType(0, 2, 1, 0, 3));
        emit(rType(32, 1, 3, 0, 4));
        emit(rType(0, 1, 4, 7, 5));
        emit(rType(0, 3, 5, 6, 6));
        emit(rType(0, 4, 6, 2, 7));
        // Store data forwarded straight from the slt
        emit(sType('h50, 7, 0));
        emit(rType(0, 1, 2, 2, 8));
        emit(sType('h40, 3, 0));
        emit(sType('h44, 4, 0));
        emit(sType('h48, 5, 0));
        emit(sType('h4C, 6, 0));
        emit(sType('h54, 8, 0));
        endProgram();
        resetCore(name);
        waitDone(name);
        checkStore({name, " add"}, 'h40, sum);
        checkStore({name, " sub"}, 'h44, diff);
        checkStore({name, " and"}, 'h48, andV);
        checkStore({name, " or"}, 'h4C, orV);
        checkStore({name, " slt"}, 'h50, sltV);
        checkStore({name, " slt reversed"}, 'h54, sltRev);
    endtask

    task automatic testLoadUse();
        int rndA;
        int rndB;
        rndA = $random(seed);
        rndB = $random(seed);
        startProgram();
        emit(iType(rndA, 0, 0, 1, 7'b0010011));
        emit(iType(rndB, 0, 0, 2, 7'b0010011));
        emit(sType('h80, 1, 0));
        emit(iType('h80, 0, 2, 3, 7'b0000011));
        emit(rType(0, 2, 3, 0, 4));
        emit(sType('h84, 4, 0));
        emit(iType('h80, 0, 2, 5, 7'b0000011));
        emit(sType('h88, 5, 0));
        emit(iType('h90, 0, 2, 6, 7'b0000011));
        emit(sType('h8C, 6, 0));
        endProgram();
        resetCore("load-use");
        waitDone("load-use");
        checkStore("load-use first store", 'h80, sext12(rndA));
        checkStore("load-use add", 'h84, sext12(rndA) + sext12(rndB));
        checkStore("load-use store data", 'h88, sext12(rndA));
        checkStore("load-use preloaded word", 'h8C, 32'hDA7A_0000 + 36);
    endtask

    task automatic testBranch();
        startProgram();
        emit(iType(5, 0, 0, 1, 7'b0010011));
        emit(iType(5, 0, 0, 2, 7'b0010011));
        emit(iType(7, 0, 0, 3, 7'b0010011));
        emit(bType(12, 2, 1, 0));
        emit(sType('hC0, 1, 0));
        emit(sType('hC4, 1, 0));
        emit(bType(8, 3, 1, 0));
        emit(sType('hC8, 3, 0));
        emit(bType(12, 3, 1, 1));
        emit(sType('hCC, 1, 0));
        emit(sType('hD0, 1, 0));
        emit(bType(8, 2, 1, 1));
        emit(sType('hD4, 2, 0));
        endProgram();
        resetCore("branch");
        waitDone("branch");
        checkNoStore("beq taken", 'hC0);
        checkNoStore("beq taken", 'hC4);
        checkStore("beq not taken", 'hC8, 32'd7);
        checkNoStore("bne taken", 'hCC);
        checkNoStore("bne taken", 'hD0);
        checkStore("bne not taken", 'hD4, 32'd5);
    endtask

    task automatic testJalLui();
        int          rndU;
        logic [31:0] link;
        logic [31:0] upper;
        rndU  = $random(seed);
        // jal sits at word 2
        link  = `PC_START + 32'd8 + 32'd4;
        upper = {rndU[19:0], 12'b0};
        startProgram();
        emit(iType('h123, 0, 0, 0, 7'b0010011));
        emit(sType('h108, 0, 0));
        emit(jType(8, 1));
        emit(sType('h10C, 1, 0));
        emit(sType('h100, 1, 0));
        emit(uType(rndU, 5));
        emit(rType(0, 1, 5, 0, 6));
        emit(sType('h104, 5, 0));
        emit(sType('h110, 6, 0));
        endProgram();
        resetCore("jal lui");
        waitDone("jal lui");
        checkStore("x0 write ignored", 'h108, 32'd0);
        checkNoStore("jal shadow", 'h10C);
        checkStore("jal link", 'h100, link);
        checkStore("lui", 'h104, upper);
        checkValue("lui low bits", 32'd0, lastStore('h104) & 32'hFFF);
        checkStore("lui plus link", 'h110, upper + link);
    endtask

    initial begin
        seed     = 60;
        errors   = 0;
        checks   = 0;
        reset    = 1'b1;
        doneSeen = 1'b0;
        for (int i = 0; i < 256; i++) begin
            dataMem[i] = 32'hDA7A_0000 + i;
        end
        startProgram();
        testReset();
        testAlu("alu round 1");
        testAlu("alu round 2");
        testLoadUse();
        testBranch();
        testJalLui();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== coreTop.sv ====
// ##########################################################
// RV32I five-stage core with instruction and data ports
// ##########################################################
`timescale 1ns/1ps
`include "coreMacros.svh"

module coreTop (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] instrF_i,
    input  logic [`XLEN-1:0] readDataM_i,
    output logic [`XLEN-1:0] pcF_o,
    output logic [`XLEN-1:0] dataAddrM_o,
    output logic [`XLEN-1:0] writeDataM_o,
    output logic             memWriteM_o
);

    logic [`XLEN-1:0]       pcD, pcPlus4D, immD, rd1D, rd2D;
    logic [`XLEN-1:0]       targetE, aluResultE, writeDataE, pcPlus4E, immE;
    logic [`XLEN-1:0]       forwardM, resultW;
    logic [`REG_ADDR_W-1:0] rs1D, rs2D, rdD, rs1E, rs2E, rdE, rdM, rdW;
    logic                   aluSrcImmD, regWriteD, memWriteD, branchD, bneD, jumpD;
    logic                   loadE, redirect, regWriteE, memWriteE, regWriteM, regWriteW;
    logic                   stallF, stallD, flushD, flushE;
    corePkg::aluOpT         aluOpD;
    corePkg::resultSrcT     resultSrcD, resultSrcE;
    corePkg::forwardT       forwardA, forwardB;

    coreDecode decodeStage (
        .clk(clk), .reset(reset), .instrF_i(instrF_i),
        .stallF_i(stallF), .stallD_i(stallD), .flushD_i(flushD),
        .redirect_i(redirect), .targetE_i(targetE),
        .pcF_o(pcF_o), .pcD_o(pcD), .pcPlus4D_o(pcPlus4D),
        .rs1D_o(rs1D), .rs2D_o(rs2D), .rdD_o(rdD), .immD_o(immD),
        .aluOpD_o(aluOpD), .resultSrcD_o(resultSrcD), .aluSrcImmD_o(aluSrcImmD),
        .regWriteD_o(regWriteD), .memWriteD_o(memWriteD),
        .branchD_o(branchD), .bneD_o(bneD), .jumpD_o(jumpD)
    );

    coreRegFile regFile (
        .clk(clk), .rs1_i(rs1D), .rs2_i(rs2D),
        .rdW_i(rdW), .resultW_i(resultW), .regWriteW_i(regWriteW),
        .rd1_o(rd1D), .rd2_o(rd2D)
    );

    coreHazard hazardUnit (
        .rs1D_i(rs1D), .rs2D_i(rs2D), .rs1E_i(rs1E), .rs2E_i(rs2E),
        .rdE_i(rdE), .loadE_i(loadE), .rdM_i(rdM), .regWriteM_i(regWriteM),
        .rdW_i(rdW), .regWriteW_i(regWriteW), .redirect_i(redirect),
        .stallF_o(stallF), .stallD_o(stallD), .flushD_o(flushD), .flushE_o(flushE),
        .forwardA_o(forwardA), .forwardB_o(forwardB)
    );

    coreExecute executeStage (
        .clk(clk), .reset(reset), .flushE_i(flushE),
        .pcD_i(pcD), .pcPlus4D_i(pcPlus4D), .rs1D_i(rs1D), .rs2D_i(rs2D),
        .rdD_i(rdD), .immD_i(immD), .aluOpD_i(aluOpD), .resultSrcD_i(resultSrcD),
        .aluSrcImmD_i(aluSrcImmD), .regWriteD_i(regWriteD), .memWriteD_i(memWriteD),
        .branchD_i(branchD), .bneD_i(bneD), .jumpD_i(jumpD),
        .rd1D_i(rd1D), .rd2D_i(rd2D), .forwardA_i(forwardA), .forwardB_i(forwardB),
        .forwardM_i(forwardM), .resultW_i(resultW),
        .rs1E_o(rs1E), .rs2E_o(rs2E), .rdE_o(rdE), .loadE_o(loadE),
        .redirect_o(redirect), .targetE_o(targetE), .aluResultE_o(aluResultE),
        .writeDataE_o(writeDataE), .pcPlus4E_o(pcPlus4E), .immE_o(immE),
        .resultSrcE_o(resultSrcE), .regWriteE_o(regWriteE), .memWriteE_o(memWriteE)
    );

    coreResult resultStage (
        .clk(clk), .reset(reset), .rdE_i(rdE),
        .aluResultE_i(aluResultE), .writeDataE_i(writeDataE),
        .pcPlus4E_i(pcPlus4E), .immE_i(immE), .resultSrcE_i(resultSrcE),
        .regWriteE_i(regWriteE), .memWriteE_i(memWriteE), .readDataM_i(readDataM_i),
        .dataAddrM_o(dataAddrM_o), .writeDataM_o(writeDataM_o), .memWriteM_o(memWriteM_o),
        .forwardM_o(forwardM), .rdM_o(rdM), .regWriteM_o(regWriteM),
        .rdW_o(rdW), .regWriteW_o(regWriteW), .resultW_o(resultW)
    );

endmodule

// ==== coreResult.sv ====
// ##########################################################
// Memory and writeback registers with the result mux
// ##########################################################
`timescale 1ns/1ps
`include "coreMacros.svh"

module coreResult (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] rdE_i,
    input  logic [`XLEN-1:0]       aluResultE_i,
    input  logic [`XLEN-1:0]       writeDataE_i,
    input  logic [`XLEN-1:0]       pcPlus4E_i,
    input  logic [`XLEN-1:0]       immE_i,
    input  corePkg::resultSrcT     resultSrcE_i,
    input  logic                   regWriteE_i,
    input  logic                   memWriteE_i,
    input  logic [`XLEN-1:0]       readDataM_i,
    output logic [`XLEN-1:0]       dataAddrM_o,
    output logic [`XLEN-1:0]       writeDataM_o,
    output logic                   memWriteM_o,
    output logic [`XLEN-1:0]       forwardM_o,
    output logic [`REG_ADDR_W-1:0] rdM_o,
    output logic                   regWriteM_o,
    output logic [`REG_ADDR_W-1:0] rdW_o,
    output logic                   regWriteW_o,
    output logic [`XLEN-1:0]       resultW_o
);

    corePkg::resultSrcT resultSrcM;
    corePkg::resultSrcT resultSrcW;
    logic [`XLEN-1:0]   pcPlus4M;
    logic [`XLEN-1:0]   immM;
    logic [`XLEN-1:0]   passW;
    logic [`XLEN-1:0]   readDataW;

    always_ff @(posedge clk) begin
        if (reset) begin
            resultSrcM  <= corePkg::resAlu;
            resultSrcW  <= corePkg::resAlu;
            memWriteM_o <= 1'b0;
            regWriteM_o <= 1'b0;
            regWriteW_o <= 1'b0;
        end else begin
            resultSrcM  <= resultSrcE_i;
            resultSrcW  <= resultSrcM;
            memWriteM_o <= memWriteE_i;
            regWriteM_o <= regWriteE_i;
            regWriteW_o <= regWriteM_o;
        end
    end

    // Non-load results travel on as one word
    always_ff @(posedge clk) begin
        dataAddrM_o  <= aluResultE_i;
        writeDataM_o <= writeDataE_i;
        pcPlus4M     <= pcPlus4E_i;
        immM         <= immE_i;
        rdM_o        <= rdE_i;
        passW        <= forwardM_o;
        readDataW    <= readDataM_i;
        rdW_o        <= rdM_o;
    end

    // A load never forwards from here; the load-use stall covers it
    always_comb begin
        case (resultSrcM)
            corePkg::resPcPlus4: forwardM_o = pcPlus4M;
            corePkg::resImm:     forwardM_o = immM;
            default:             forwardM_o = dataAddrM_o;
        endcase
    end

    assign resultW_o = (resultSrcW == corePkg::resMem) ? readDataW : passW;

endmodule

// ==== coreExecute.sv ====
// ##########################################################
// Execute stage: pipeline register, forwarding, ALU and
// branch resolution with redirect to fetch
// ##########################################################
`timescale 1ns/1ps
`include "coreMacros.svh"

module coreExecute (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flushE_i,
    input  logic [`XLEN-1:0]       pcD_i,
    input  logic [`XLEN-1:0]       pcPlus4D_i,
    input  logic [`REG_ADDR_W-1:0] rs1D_i,
    input  logic [`REG_ADDR_W-1:0] rs2D_i,
    input  logic [`REG_ADDR_W-1:0] rdD_i,
    input  logic [`XLEN-1:0]       immD_i,
    input  corePkg::aluOpT         aluOpD_i,
    input  corePkg::resultSrcT     resultSrcD_i,
    input  logic                   aluSrcImmD_i,
    input  logic                   regWriteD_i,
    input  logic                   memWriteD_i,
    input  logic                   branchD_i,
    input  logic                   bneD_i,
    input  logic                   jumpD_i,
    input  logic [`XLEN-1:0]       rd1D_i,
    input  logic [`XLEN-1:0]       rd2D_i,
    input  corePkg::forwardT       forwardA_i,
    input  corePkg::forwardT       forwardB_i,
    input  logic [`XLEN-1:0]       forwardM_i,
    input  logic [`XLEN-1:0]       resultW_i,
    output logic [`REG_ADDR_W-1:0] rs1E_o,
    output logic [`REG_ADDR_W-1:0] rs2E_o,
    output logic [`REG_ADDR_W-1:0] rdE_o,
    output logic                   loadE_o,
    output logic                   redirect_o,
    output logic [`XLEN-1:0]       targetE_o,
    output logic [`XLEN-1:0]       aluResultE_o,
    output logic [`XLEN-1:0]       writeDataE_o,
    output logic [`XLEN-1:0]       pcPlus4E_o,
    output logic [`XLEN-1:0]       immE_o,
    output corePkg::resultSrcT     resultSrcE_o,
    output logic                   regWriteE_o,
    output logic                   memWriteE_o
);

    logic [`XLEN-1:0] pcE;
    logic [`XLEN-1:0] rd1E;
    logic [`XLEN-1:0] rd2E;
    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] srcB;
    corePkg::aluOpT   aluOpE;
    logic             aluSrcImmE;
    logic             branchE;
    logic             bneE;
    logic             jumpE;
    logic             zeroE;

    function automatic logic [`XLEN-1:0] fwdMux(input corePkg::forwardT sel,
                                                input logic [`XLEN-1:0] regVal);
        case (sel)
            corePkg::fwdMem: fwdMux = forwardM_i;
            corePkg::fwdWb:  fwdMux = resultW_i;
            default:         fwdMux = regVal;
        endcase
    endfunction

    // A flush turns the stage into a bubble
    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            resultSrcE_o <= corePkg::resAlu;
            regWriteE_o  <= 1'b0;
            memWriteE_o  <= 1'b0;
            branchE      <= 1'b0;
            jumpE        <= 1'b0;
        end else begin
            resultSrcE_o <= resultSrcD_i;
            regWriteE_o  <= regWriteD_i;
            memWriteE_o  <= memWriteD_i;
            branchE      <= branchD_i;
            jumpE        <= jumpD_i;
        end
    end

    always_ff @(posedge clk) begin
        pcE        <= pcD_i;
        pcPlus4E_o <= pcPlus4D_i;
        immE_o     <= immD_i;
        rd1E       <= rd1D_i;
        rd2E       <= rd2D_i;
        rs1E_o     <= rs1D_i;
        rs2E_o     <= rs2D_i;
        rdE_o      <= rdD_i;
        aluOpE     <= aluOpD_i;
        aluSrcImmE <= aluSrcImmD_i;
        bneE       <= bneD_i;
    end

    always_comb begin
        srcA         = fwdMux(forwardA_i, rd1E);
        writeDataE_o = fwdMux(forwardB_i, rd2E);
        srcB         = aluSrcImmE ? immE_o : writeDataE_o;
        case (aluOpE)
            corePkg::aluSub: aluResultE_o = srcA - srcB;
            corePkg::aluAnd: aluResultE_o = srcA & srcB;
            corePkg::aluOr:  aluResultE_o = srcA | srcB;
            corePkg::aluSlt: aluResultE_o = {{(`XLEN - 1){1'b0}}, $signed(srcA) < $signed(srcB)};
            default:         aluResultE_o = srcA + srcB;
        endcase
    end

    assign zeroE      = (aluResultE_o == '0);
    assign redirect_o = jumpE || (branchE && (zeroE != bneE));
    assign targetE_o  = pcE + immE_o;
    assign loadE_o    = regWriteE_o && (resultSrcE_o == corePkg::resMem);

    aluOpKnown: assert property (@(posedge clk) disable iff (reset)
        regWriteE_o |-> aluOpE inside {corePkg::aluAdd, corePkg::aluSub, corePkg::aluAnd,
                                       corePkg::aluOr, corePkg::aluSlt})
        else $error("Unknown ALU operation on a register write");

endmodule

// ==== coreHazard.sv ====
// ##########################################################
// Hazard unit: forward selects, load-use stall, flushes
// ##########################################################
`timescale 1ns/1ps
`include "coreMacros.svh"

module coreHazard (
    input  logic [`REG_ADDR_W-1:0] rs1D_i,
    input  logic [`REG_ADDR_W-1:0] rs2D_i,
    input  logic [`REG_ADDR_W-1:0] rs1E_i,
    input  logic [`REG_ADDR_W-1:0] rs2E_i,
    input  logic [`REG_ADDR_W-1:0] rdE_i,
    input  logic                   loadE_i,
    input  logic [`REG_ADDR_W-1:0] rdM_i,
    input  logic                   regWriteM_i,
    input  logic [`REG_ADDR_W-1:0] rdW_i,
    input  logic                   regWriteW_i,
    input  logic                   redirect_i,
    output logic                   stallF_o,
    output logic                   stallD_o,
    output logic                   flushD_o,
    output logic                   flushE_o,
    output corePkg::forwardT       forwardA_o,
    output corePkg::forwardT       forwardB_o
);

    logic loadUse;

    // Memory stage is younger, so it wins over writeback
    function automatic corePkg::forwardT pickForward(input logic [`REG_ADDR_W-1:0] rs);
        if (rs == '0) begin
            pickForward = corePkg::fwdReg;
        end else if (regWriteM_i && (rdM_i == rs)) begin
            pickForward = corePkg::fwdMem;
        end else if (regWriteW_i && (rdW_i == rs)) begin
            pickForward = corePkg::fwdWb;
        end else begin
            pickForward = corePkg::fwdReg;
        end
    endfunction

    always_comb begin
        forwardA_o = pickForward(rs1E_i);
        forwardB_o = pickForward(rs2E_i);
    end

    // Load data exists only from writeback on
    assign loadUse = loadE_i && (rdE_i != '0) && ((rdE_i == rs1D_i) || (rdE_i == rs2D_i));

    assign stallF_o = loadUse;
    assign stallD_o = loadUse;
    assign flushD_o = redirect_i;
    assign flushE_o = redirect_i || loadUse;

    // A held PC would drop the branch target
    always_comb begin
        redirectKept: assert final (!((redirect_i === 1'b1) && (stallF_o === 1'b1)))
            else $error("Redirect lost to a load-use stall");
    end

endmodule

// ==== coreDecode.sv ====
// ##########################################################
// Fetch and decode: PC register, decode register, control
// decoder and immediate extension
// ##########################################################
`timescale 1ns/1ps
`include "coreMacros.svh"

module coreDecode (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`XLEN-1:0]       instrF_i,
    input  logic                   stallF_i,
    input  logic                   stallD_i,
    input  logic                   flushD_i,
    input  logic                   redirect_i,
    input  logic [`XLEN-1:0]       targetE_i,
    output logic [`XLEN-1:0]       pcF_o,
    output logic [`XLEN-1:0]       pcD_o,
    output logic [`XLEN-1:0]       pcPlus4D_o,
    output logic [`REG_ADDR_W-1:0] rs1D_o,
    output logic [`REG_ADDR_W-1:0] rs2D_o,
    output logic [`REG_ADDR_W-1:0] rdD_o,
    output logic [`XLEN-1:0]       immD_o,
    output corePkg::aluOpT         aluOpD_o,
    output corePkg::resultSrcT     resultSrcD_o,
    output logic                   aluSrcImmD_o,
    output logic                   regWriteD_o,
    output logic                   memWriteD_o,
    output logic                   branchD_o,
    output logic                   bneD_o,
    output logic                   jumpD_o
);

    logic [`XLEN-1:0] instrD;
    logic [`XLEN-1:0] pcPlus4F;
    corePkg::opcodeT  opcodeD;
    corePkg::immSrcT  immSrcD;

    // Only sub looks at funct7
    function automatic corePkg::aluOpT aluFromFunct(input logic [2:0] funct3, input logic sub);
        case (funct3)
            3'b000:  aluFromFunct = sub ? corePkg::aluSub : corePkg::aluAdd;
            3'b010:  aluFromFunct = corePkg::aluSlt;
            3'b110:  aluFromFunct = corePkg::aluOr;
            3'b111:  aluFromFunct = corePkg::aluAnd;
            default: aluFromFunct = corePkg::aluAdd;
        endcase
    endfunction

    assign pcPlus4F = pcF_o + 4;

    // Static not-taken fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= `PC_START;
        end else if (!stallF_i) begin
            pcF_o <= redirect_i ? targetE_i : pcPlus4F;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            instrD <= `NOP_INSTR;
        end else if (!stallD_i) begin
            instrD <= instrF_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD_i) begin
            pcD_o      <= pcF_o;
            pcPlus4D_o <= pcPlus4F;
        end
    end

    assign opcodeD = corePkg::opcodeT'(instrD[6:0]);
    assign rdD_o   = instrD[11:7];
    assign rs1D_o  = instrD[19:15];
    assign rs2D_o  = instrD[24:20];

    always_comb begin
        aluOpD_o     = corePkg::aluAdd;
        resultSrcD_o = corePkg::resAlu;
        immSrcD      = corePkg::immI;
        aluSrcImmD_o = 1'b0;
        regWriteD_o  = 1'b0;
        memWriteD_o  = 1'b0;
        branchD_o    = 1'b0;
        bneD_o       = 1'b0;
        jumpD_o      = 1'b0;
        case (opcodeD)
            corePkg::opcOp: begin
                regWriteD_o = 1'b1;
                aluOpD_o    = aluFromFunct(instrD[14:12], instrD[30]);
            end
            corePkg::opcOpImm: begin
                regWriteD_o  = 1'b1;
                aluSrcImmD_o = 1'b1;
                aluOpD_o     = aluFromFunct(instrD[14:12], 1'b0);
            end
            corePkg::opcLoad: begin
                regWriteD_o  = 1'b1;
                aluSrcImmD_o = 1'b1;
                resultSrcD_o = corePkg::resMem;
            end
            corePkg::opcStore: begin
                memWriteD_o  = 1'b1;
                aluSrcImmD_o = 1'b1;
                immSrcD      = corePkg::immS;
            end
            corePkg::opcBranch: begin
                // funct3 bit 0 splits bne from beq
                branchD_o = 1'b1;
                bneD_o    = instrD[12];
                aluOpD_o  = corePkg::aluSub;
                immSrcD   = corePkg::immB;
            end
            corePkg::opcJal: begin
                regWriteD_o  = 1'b1;
                jumpD_o      = 1'b1;
                resultSrcD_o = corePkg::resPcPlus4;
                immSrcD      = corePkg::immJ;
            end
            corePkg::opcLui: begin
                regWriteD_o  = 1'b1;
                resultSrcD_o = corePkg::resImm;
                immSrcD      = corePkg::immU;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (immSrcD)
            corePkg::immS: immD_o = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            corePkg::immB: immD_o = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            corePkg::immJ: immD_o = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            corePkg::immU: immD_o = {instrD[31:12], 12'b0};
            default:       immD_o = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    // Branch targets come back from execute
    pcAligned: assert property (@(posedge clk) disable iff (reset) pcF_o[1:0] == 2'b00)
        else $error("PC not word-aligned: %h", pcF_o);

endmodule

// ==== coreRegFile.sv ====
// ##########################################################
// Register file with two reads and one write, x0 tied to 0
// ##########################################################
`timescale 1ns/1ps
`include "coreMacros.svh"

module coreRegFile (
    input  logic                   clk,
    input  logic [`REG_ADDR_W-1:0] rs1_i,
    input  logic [`REG_ADDR_W-1:0] rs2_i,
    input  logic [`REG_ADDR_W-1:0] rdW_i,
    input  logic [`XLEN-1:0]       resultW_i,
    input  logic                   regWriteW_i,
    output logic [`XLEN-1:0]       rd1_o,
    output logic [`XLEN-1:0]       rd2_o
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:(1 << `REG_ADDR_W) - 1];

    // Falling-edge write so decode reads the new value in the same cycle
    always_ff @(negedge clk) begin
        if (regWriteW_i && (rdW_i != '0)) begin
            regs[rdW_i] <= resultW_i;
        end
    end

    assign rd1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rd2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// ==== corePkg.sv ====
// ##########################################################
// Core package with the enums shared by the pipeline stages
// ##########################################################
package corePkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opcOp     = 7'b0110011,
        opcOpImm  = 7'b0010011,
        opcLoad   = 7'b0000011,
        opcStore  = 7'b0100011,
        opcBranch = 7'b1100011,
        opcJal    = 7'b1101111,
        opcLui    = 7'b0110111
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOpT;

    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immJ = 3'd3,
        immU = 3'd4
    } immSrcT;

    // What a stage hands back as the register result
    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2,
        resImm     = 2'd3
    } resultSrcT;

    typedef enum logic [1:0] {
        fwdReg = 2'd0,
        fwdWb  = 2'd1,
        fwdMem = 2'd2
    } forwardT;

endpackage

// ==== coreMacros.svh ====
// ##########################################################
// Core macros for datapath widths, the reset PC and the
// encoding of the NOP that fills a cleared decode stage
// ##########################################################
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data and address width
`define XLEN 32

// Register index width
`define REG_ADDR_W 5

// Fetch starts here out of reset
`define PC_START 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif
